//--- dccm_mem.f
+incdir+hw
hw/dccm_pkg.sv
hw/dccm_bank_if.sv
hw/dccm_bank_steer.sv
hw/dccm_bank_ram.sv
hw/dccm_read_align.sv
hw/dccm_mem.sv
tests/dccm_clock_gen.sv
tests/dccm_checker.sv
tests/dccm_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the DCCM testbench with Verilator, then searches the log for the result
set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=dccm_sim

rm -f "$LOG"

verilator --binary --timing --top-module dccm_tb -f dccm_mem.f -o "$BIN" \
   && ./obj_dir/"$BIN" | tee "$LOG" \
   || { echo "Simulation did not build or run to completion"; exit 1; }

grep -q "Test FAILED" "$LOG" \
   && { echo "Simulation result: failure"; exit 1; } \
   || echo "No failure found in $LOG"

grep -q "Test OK" "$LOG" \
   && { echo "Simulation result: success"; exit 0; } \
   || { echo "Simulation result: no pass line in $LOG"; exit 1; }

//--- tests/dccm_tb.sv
// Testbench top; one table entry per clock after reset, a write and a read never share a cycle
`timescale 1ns/1ps
`include "dccm_settings.svh"

module dccm_tb;
   import dccm_pkg::*;

   localparam int SEED         = 95034;
   localparam int RESET_CYCLES = 10;
   localparam int SPARE_CYCLES = 20;
   localparam int DONE_ID      = 99;

   typedef enum logic [1:0] {
      OP_IDLE,
      OP_WRITE,
      OP_READ
   } op_e;

   // One stimulus table entry
   typedef struct packed {
      op_e        op;
      int         test;
      dccm_addr_u addr_lo;
      dccm_addr_u addr_hi;
      dccm_word_t data_lo;
      dccm_word_t data_hi;
   } entry_t;

   logic       clk;
   logic       rst_n;
   logic       wren;
   logic       rden;
   dccm_addr_u wr_addr_lo;
   dccm_addr_u wr_addr_hi;
   dccm_addr_u rd_addr_lo;
   dccm_addr_u rd_addr_hi;
   dccm_word_t wr_data_lo;
   dccm_word_t wr_data_hi;
   dccm_word_t rd_data_lo;
   dccm_word_t rd_data_hi;

   int         test_id;
   int         checks;
   int         errors;
   int         num_tests;
   int         timeout_limit = 0;
   int         cycles = 0;
   entry_t     stim_q [$];

   dccm_clock_gen #(.HALF_PERIOD(4), .RESET_CYCLES(RESET_CYCLES)) clock_i (
      .clk   (clk),
      .rst_n (rst_n)
   );

   dccm_mem dut_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .wren       (wren),
      .rden       (rden),
      .wr_addr_lo (wr_addr_lo),
      .wr_addr_hi (wr_addr_hi),
      .rd_addr_lo (rd_addr_lo),
      .rd_addr_hi (rd_addr_hi),
      .wr_data_lo (wr_data_lo),
      .wr_data_hi (wr_data_hi),
      .rd_data_lo (rd_data_lo),
      .rd_data_hi (rd_data_hi)
   );

   dccm_checker checker_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .wren       (wren),
      .rden       (rden),
      .wr_addr_lo (wr_addr_lo),
      .wr_addr_hi (wr_addr_hi),
      .rd_addr_lo (rd_addr_lo),
      .rd_addr_hi (rd_addr_hi),
      .wr_data_lo (wr_data_lo),
      .wr_data_hi (wr_data_hi),
      .rd_data_lo (rd_data_lo),
      .rd_data_hi (rd_data_hi),
      .test_id    (test_id),
      .checks     (checks),
      .errors     (errors)
   );

   // Word-aligned byte address from index and bank
   function automatic dccm_addr_u make_addr(input int index, input int bank);
      dccm_addr_u a;
      a.fields.index  = dccm_index_t'(index);
      a.fields.bank   = dccm_bank_sel_t'(bank);
      a.fields.offset = '0;
      return a;
   endfunction

   // Next 4-byte word, so bank 7 rolls over to bank 0 of the next index
   function automatic dccm_addr_u next_word(input dccm_addr_u a);
      dccm_addr_u n;
      n.word = a.word + `DCCM_ADDR_WIDTH'(4);
      return n;
   endfunction

   function automatic dccm_word_t rand_word();
      return dccm_word_t'({$urandom, $urandom});
   endfunction

   task automatic add_entry(input op_e op, input int test, input dccm_addr_u lo,
                            input logic misaligned);
      entry_t e;
      e.op      = op;
      e.test    = test;
      e.addr_lo = lo;
      e.addr_hi = misaligned ? next_word(lo) : lo;
      e.data_lo = (op == OP_WRITE) ? rand_word() : '0;
      e.data_hi = (op == OP_WRITE) ? rand_word() : '0;
      stim_q.push_back(e);
   endtask

   // Each test ends on an idle entry so its last read is compared before the next test
   task automatic build_table();
      // Outputs right after reset
      add_entry(OP_IDLE, 0, make_addr(0, 0), 1'b0);
      add_entry(OP_IDLE, 0, make_addr(0, 0), 1'b0);

      // Every bank at index 5, then read back one per cycle
      for (int b = 0; b < `DCCM_NUM_BANKS; b++) begin
         add_entry(OP_WRITE, 1, make_addr(5, b), 1'b0);
      end
      for (int b = 0; b < `DCCM_NUM_BANKS; b++) begin
         add_entry(OP_READ, 1, make_addr(5, b), 1'b0);
      end
      add_entry(OP_IDLE, 1, make_addr(0, 0), 1'b0);

      // Misaligned writes, the second one crossing from bank 7 into bank 0
      add_entry(OP_WRITE, 2, make_addr(9, 2), 1'b1);
      add_entry(OP_WRITE, 2, make_addr(12, 7), 1'b1);
      add_entry(OP_READ, 2, make_addr(9, 2), 1'b0);
      add_entry(OP_READ, 2, make_addr(9, 3), 1'b0);
      add_entry(OP_READ, 2, make_addr(12, 7), 1'b0);
      add_entry(OP_READ, 2, make_addr(13, 0), 1'b0);
      add_entry(OP_IDLE, 2, make_addr(0, 0), 1'b0);

      // Aligned writes, then misaligned reads spanning them
      add_entry(OP_WRITE, 3, make_addr(20, 5), 1'b0);
      add_entry(OP_WRITE, 3, make_addr(20, 6), 1'b0);
      add_entry(OP_WRITE, 3, make_addr(30, 7), 1'b0);
      add_entry(OP_WRITE, 3, make_addr(31, 0), 1'b0);
      add_entry(OP_READ, 3, make_addr(20, 5), 1'b1);
      add_entry(OP_READ, 3, make_addr(30, 7), 1'b1);
      add_entry(OP_IDLE, 3, make_addr(0, 0), 1'b0);

      // Back-to-back reads, then reads right behind their writes
      add_entry(OP_READ, 4, make_addr(5, 3), 1'b0);
      add_entry(OP_READ, 4, make_addr(5, 0), 1'b0);
      add_entry(OP_READ, 4, make_addr(5, 7), 1'b0);
      add_entry(OP_READ, 4, make_addr(5, 4), 1'b0);
      add_entry(OP_WRITE, 4, make_addr(33, 1), 1'b0);
      add_entry(OP_READ, 4, make_addr(33, 1), 1'b0);
      add_entry(OP_WRITE, 4, make_addr(40, 7), 1'b1);
      add_entry(OP_READ, 4, make_addr(40, 7), 1'b1);
      add_entry(OP_IDLE, 4, make_addr(0, 0), 1'b0);
   endtask

   task automatic apply_entry(input entry_t e);
      test_id    = e.test;
      wren       = (e.op == OP_WRITE);
      rden       = (e.op == OP_READ);
      wr_addr_lo = e.addr_lo;
      wr_addr_hi = e.addr_hi;
      rd_addr_lo = e.addr_lo;
      rd_addr_hi = e.addr_hi;
      wr_data_lo = e.data_lo;
      wr_data_hi = e.data_hi;
   endtask

   initial begin
      wren       = 1'b0;
      rden       = 1'b0;
      wr_addr_lo = '0;
      wr_addr_hi = '0;
      rd_addr_lo = '0;
      rd_addr_hi = '0;
      wr_data_lo = '0;
      wr_data_hi = '0;
      test_id    = 0;

      void'($urandom(SEED));
      build_table();
      num_tests     = stim_q[stim_q.size() - 1].test + 1;
      timeout_limit = stim_q.size() + RESET_CYCLES + SPARE_CYCLES;

      @(posedge rst_n);
      foreach (stim_q[i]) begin
         @(negedge clk);
         apply_entry(stim_q[i]);
      end

      // Close the last test, then let the checker report it
      @(negedge clk);
      wren    = 1'b0;
      rden    = 1'b0;
      test_id = DONE_ID;
      @(posedge clk);
      @(posedge clk);

      $display("Summary: %0d tests, %0d checks, %0d mismatches", num_tests, checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // Hang guard
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (timeout_limit > 0 && cycles >= timeout_limit) begin
         $display("Timeout: the run hung and did not finish within %0d cycles", timeout_limit);
         $display("Test FAILED");
         $finish;
      end
   end

endmodule

//--- tests/dccm_checker.sv
// Reference model of the DCCM; only words that were written earlier in the run may be read
`timescale 1ns/1ps
`include "dccm_settings.svh"

module dccm_checker (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 wren,
   input  logic                 rden,
   input  dccm_pkg::dccm_addr_u wr_addr_lo,
   input  dccm_pkg::dccm_addr_u wr_addr_hi,
   input  dccm_pkg::dccm_addr_u rd_addr_lo,
   input  dccm_pkg::dccm_addr_u rd_addr_hi,
   input  dccm_pkg::dccm_word_t wr_data_lo,
   input  dccm_pkg::dccm_word_t wr_data_hi,
   input  dccm_pkg::dccm_word_t rd_data_lo,
   input  dccm_pkg::dccm_word_t rd_data_hi,
   input  int                   test_id,
   output int                   checks,
   output int                   errors
);
   import dccm_pkg::*;

   // Expected contents, by bank and index
   dccm_word_t ref_mem [`DCCM_NUM_BANKS][`DCCM_INDEX_DEPTH];

   // Words the outputs must show until the next read
   dccm_word_t exp_lo;
   dccm_word_t exp_hi;

   logic active = 1'b0;
   int   cur_test = 0;
   int   test_checks = 0;
   int   test_errors = 0;
   int   check_count = 0;
   int   error_count = 0;

   assign checks = check_count;
   assign errors = error_count;

   function automatic string test_name(input int id);
      case (id)
         0:       return "reset values";
         1:       return "aligned write and read of every bank";
         2:       return "misaligned write with bank wrap";
         3:       return "misaligned read";
         4:       return "back-to-back reads, write then read";
         default: return "unnamed";
      endcase
   endfunction

   task automatic compare_word(input string name, input dccm_word_t got,
                               input dccm_word_t want);
      check_count++;
      test_checks++;
      if (got !== want) begin
         error_count++;
         test_errors++;
         $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, got, want);
      end
   endtask

   // Inputs are sampled at the rising edge, outputs compared at the falling edge
   always begin
      @(posedge clk);
      active = rst_n;
      if (!rst_n) begin
         exp_lo = '0;
         exp_hi = '0;
      end else begin
         // Lo word always goes to the lo bank, hi word only when a second bank is hit
         if (wren) begin
            ref_mem[wr_addr_lo.fields.bank][wr_addr_lo.fields.index] = wr_data_lo;
            if (wr_addr_hi.fields.bank != wr_addr_lo.fields.bank) begin
               ref_mem[wr_addr_hi.fields.bank][wr_addr_hi.fields.index] = wr_data_hi;
            end
         end
         if (rden) begin
            exp_lo = ref_mem[rd_addr_lo.fields.bank][rd_addr_lo.fields.index];
            exp_hi = ref_mem[rd_addr_hi.fields.bank][rd_addr_hi.fields.index];
         end
      end

      // A new test id means the previous test has run all its entries
      if (test_id != cur_test) begin
         $display("test %0d (%s) finished: %0d checks, %0d mismatches, %s",
                  cur_test, test_name(cur_test), test_checks, test_errors,
                  (test_errors == 0) ? "passed" : "failed");
         cur_test    = test_id;
         test_checks = 0;
         test_errors = 0;
      end

      @(negedge clk);
      if (active) begin
         compare_word("rd_data_lo", rd_data_lo, exp_lo);
         compare_word("rd_data_hi", rd_data_hi, exp_hi);
      end
   end

endmodule

//--- tests/dccm_clock_gen.sv
// Free-running 8 ns clock; rst_n is released on a falling edge after the reset cycles
`timescale 1ns/1ps

module dccm_clock_gen #(
   parameter int HALF_PERIOD  = 4,
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   // Reset held over whole clock cycles, released away from the rising edge
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

//--- hw/dccm_mem.sv
// Banked DCCM with one-cycle reads; a read and a write to one bank in one cycle is unsupported
`timescale 1ns/1ps
`include "dccm_settings.svh"

module dccm_mem (
   input  logic                 clk,
   input  logic                 rst_n,

   // Access strobes, one access per cycle each
   input  logic                 wren,
   input  logic                 rden,

   // Lo and hi byte addresses, hi names the second bank when misaligned
   input  dccm_pkg::dccm_addr_u wr_addr_lo,
   input  dccm_pkg::dccm_addr_u wr_addr_hi,
   input  dccm_pkg::dccm_addr_u rd_addr_lo,
   input  dccm_pkg::dccm_addr_u rd_addr_hi,

   // Write words for the lo and hi banks
   input  dccm_pkg::dccm_word_t wr_data_lo,
   input  dccm_pkg::dccm_word_t wr_data_hi,

   // Read words, valid the cycle after rden
   output dccm_pkg::dccm_word_t rd_data_lo,
   output dccm_pkg::dccm_word_t rd_data_hi
);

   // Per-bank request and response
   dccm_bank_if banks ();

   // Address decode and per-bank steering
   dccm_bank_steer steer_i (
      .wren       (wren),
      .rden       (rden),
      .wr_addr_lo (wr_addr_lo),
      .wr_addr_hi (wr_addr_hi),
      .rd_addr_lo (rd_addr_lo),
      .rd_addr_hi (rd_addr_hi),
      .wr_data_lo (wr_data_lo),
      .wr_data_hi (wr_data_hi),
      .banks      (banks.steer)
   );

   // Eight banks, each wired to its own interface entry
   for (genvar i = 0; i < `DCCM_NUM_BANKS; i++) begin : g_bank
      dccm_bank_ram bank_i (
         .clk   (clk),
         .rst_n (rst_n),
         .en    (banks.en[i]),
         .we    (banks.we[i]),
         .index (banks.index[i]),
         .wdata (banks.wdata[i]),
         .rdata (banks.rdata[i])
      );
   end : g_bank

   // Lo/hi read word selection
   dccm_read_align align_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .rden       (rden),
      .rd_addr_lo (rd_addr_lo),
      .rd_addr_hi (rd_addr_hi),
      .banks      (banks.align),
      .rd_data_lo (rd_data_lo),
      .rd_data_hi (rd_data_hi)
   );

endmodule

//--- hw/dccm_read_align.sv
// Read alignment with one cycle of latency; selects hold their value between reads
`timescale 1ns/1ps

module dccm_read_align (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 rden,
   input  dccm_pkg::dccm_addr_u rd_addr_lo,
   input  dccm_pkg::dccm_addr_u rd_addr_hi,
   dccm_bank_if.align           banks,
   output dccm_pkg::dccm_word_t rd_data_lo,
   output dccm_pkg::dccm_word_t rd_data_hi
);
   import dccm_pkg::*;

   // Bank numbers of the read in flight
   dccm_bank_sel_t rd_bank_lo_q;
   dccm_bank_sel_t rd_bank_hi_q;

   // Capture selects with the read so they line up with the bank outputs
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_bank_lo_q <= '0;
         rd_bank_hi_q <= '0;
      end else if (rden) begin
         rd_bank_lo_q <= rd_addr_lo.fields.bank;
         rd_bank_hi_q <= rd_addr_hi.fields.bank;
      end
   end

   // Aligned read gives the same bank on both outputs
   assign rd_data_lo = banks.rdata[rd_bank_lo_q];
   assign rd_data_hi = banks.rdata[rd_bank_hi_q];

endmodule

//--- hw/dccm_bank_ram.sv
// Behavioral single-port bank; contents are not reset, only the read register clears
`timescale 1ns/1ps
`include "dccm_settings.svh"

module dccm_bank_ram (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  en,
   input  logic                  we,
   input  dccm_pkg::dccm_index_t index,
   input  dccm_pkg::dccm_word_t  wdata,
   output dccm_pkg::dccm_word_t  rdata
);
   import dccm_pkg::*;

   // Storage array
   dccm_word_t mem [`DCCM_INDEX_DEPTH];

   // Write at the edge
   always_ff @(posedge clk) begin
      if (en && we) begin
         mem[index] <= wdata;
      end
   end

   // Read register, holds until the next read of this bank
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rdata <= '0;
      end else if (en && !we) begin
         rdata <= mem[index];
      end
   end

endmodule

//--- hw/dccm_bank_steer.sv
// Combinational bank decode; a write and a read to the same bank in one cycle use the write index
`timescale 1ns/1ps
`include "dccm_settings.svh"

module dccm_bank_steer (
   input  logic                 wren,
   input  logic                 rden,
   input  dccm_pkg::dccm_addr_u wr_addr_lo,
   input  dccm_pkg::dccm_addr_u wr_addr_hi,
   input  dccm_pkg::dccm_addr_u rd_addr_lo,
   input  dccm_pkg::dccm_addr_u rd_addr_hi,
   input  dccm_pkg::dccm_word_t wr_data_lo,
   input  dccm_pkg::dccm_word_t wr_data_hi,
   dccm_bank_if.steer           banks
);
   import dccm_pkg::*;

   // Which banks each address selects
   logic [`DCCM_NUM_BANKS-1:0] wr_sel_lo;
   logic [`DCCM_NUM_BANKS-1:0] wr_sel_hi;
   logic [`DCCM_NUM_BANKS-1:0] rd_sel_lo;
   logic [`DCCM_NUM_BANKS-1:0] rd_sel_hi;

   // Banks touched by this cycle's write and read
   logic [`DCCM_NUM_BANKS-1:0] wr_bank;
   logic [`DCCM_NUM_BANKS-1:0] rd_bank;

   // Banks that take the hi index and data
   logic [`DCCM_NUM_BANKS-1:0] wr_use_hi;
   logic [`DCCM_NUM_BANKS-1:0] rd_use_hi;

   logic wr_unaligned;
   logic rd_unaligned;

   // Misaligned when lo and hi land in different banks
   assign wr_unaligned = (wr_addr_lo.fields.bank != wr_addr_hi.fields.bank);
   assign rd_unaligned = (rd_addr_lo.fields.bank != rd_addr_hi.fields.bank);

   // Bank decode of all four addresses
   always_comb begin
      for (int i = 0; i < `DCCM_NUM_BANKS; i++) begin
         wr_sel_lo[i] = (wr_addr_lo.fields.bank == dccm_bank_sel_t'(i));
         wr_sel_hi[i] = (wr_addr_hi.fields.bank == dccm_bank_sel_t'(i));
         rd_sel_lo[i] = (rd_addr_lo.fields.bank == dccm_bank_sel_t'(i));
         rd_sel_hi[i] = (rd_addr_hi.fields.bank == dccm_bank_sel_t'(i));
      end
   end

   assign wr_bank = {`DCCM_NUM_BANKS{wren}} & (wr_sel_lo | wr_sel_hi);
   assign rd_bank = {`DCCM_NUM_BANKS{rden}} & (rd_sel_lo | rd_sel_hi);

   // On an aligned access the hi address names the lo bank, so lo wins there
   assign wr_use_hi = wr_sel_hi & {`DCCM_NUM_BANKS{wr_unaligned}};
   assign rd_use_hi = rd_sel_hi & {`DCCM_NUM_BANKS{rd_unaligned}};

   // Plain per-bank enable, no clock gating
   assign banks.en = wr_bank | rd_bank;
   assign banks.we = wr_bank;

   // Per-bank index and write data
   always_comb begin
      for (int i = 0; i < `DCCM_NUM_BANKS; i++) begin
         // Write index has priority when both hit this bank
         if (wr_bank[i]) begin
            banks.index[i] = wr_use_hi[i] ? wr_addr_hi.fields.index
                                          : wr_addr_lo.fields.index;
         end else begin
            banks.index[i] = rd_use_hi[i] ? rd_addr_hi.fields.index
                                          : rd_addr_lo.fields.index;
         end
         banks.wdata[i] = wr_use_hi[i] ? wr_data_hi : wr_data_lo;
      end
   end

endmodule

//--- hw/dccm_bank_if.sv
// Per-bank request and response arrays; one entry per bank, no handshake or back-pressure
`timescale 1ns/1ps
`include "dccm_settings.svh"

interface dccm_bank_if;
   import dccm_pkg::*;

   // Request side, one bit or word per bank
   logic [`DCCM_NUM_BANKS-1:0] en;
   logic [`DCCM_NUM_BANKS-1:0] we;
   dccm_index_t                index [`DCCM_NUM_BANKS];
   dccm_word_t                 wdata [`DCCM_NUM_BANKS];

   // Registered read word of each bank
   dccm_word_t                 rdata [`DCCM_NUM_BANKS];

   // Address and data steering
   modport steer (
      output en,
      output we,
      output index,
      output wdata
   );

   // Bank RAMs, each taking its own entry
   modport ram (
      input  en,
      input  we,
      input  index,
      input  wdata,
      output rdata
   );

   // Read data alignment
   modport align (
      input  rdata
   );

endinterface

//--- hw/dccm_pkg.sv
// Types for the banked DCCM; check bits in a bank word are carried but never interpreted
`include "dccm_settings.svh"

package dccm_pkg;

   // One bank word, data and check bits together
   typedef logic [`DCCM_DATA_WIDTH-1:0] dccm_word_t;

   // Entry within one bank
   typedef logic [`DCCM_INDEX_BITS-1:0] dccm_index_t;

   // Bank number
   typedef logic [`DCCM_BANK_BITS-1:0] dccm_bank_sel_t;

   // Byte address split into its decode fields
   typedef struct packed {
      dccm_index_t                 index;
      dccm_bank_sel_t              bank;
      logic [`DCCM_BYTE_BITS-1:0]  offset;
   } dccm_addr_fields_t;

   // Same byte address, seen as a flat word or as fields
   typedef union packed {
      logic [`DCCM_ADDR_WIDTH-1:0] word;
      dccm_addr_fields_t           fields;
   } dccm_addr_u;

endpackage

//--- hw/dccm_settings.svh
// Bank geometry for simulation only; the 64-entry depth is far below a real DCCM size
`ifndef DCCM_SETTINGS_SVH
`define DCCM_SETTINGS_SVH

// Eight banks, selected by address bits just above the byte offset
`define DCCM_NUM_BANKS 8
`define DCCM_BANK_BITS 3

// Byte offset within a 4-byte word
`define DCCM_BYTE_BITS 2

// Entries per bank
`define DCCM_INDEX_BITS 6
`define DCCM_INDEX_DEPTH (1 << `DCCM_INDEX_BITS)

// Byte address is index, bank and offset, index highest
`define DCCM_ADDR_WIDTH (`DCCM_INDEX_BITS + `DCCM_BANK_BITS + `DCCM_BYTE_BITS)

// 32 data bits plus 7 check bits, stored as one opaque word
`define DCCM_DATA_WIDTH 39

`endif
